/* design/cpu_isa_pkg.sv */
package cpu_isa_pkg;

    // Basic data and register index types
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // Field widths of the I and J formats
    localparam int IMM_W  = 16;
    localparam int JUMP_W = 26;

    // Primary opcode, bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // Function field of SPECIAL, bits 5:0
    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funct_e;

endpackage

/* design/cpu_pipe_pkg.sv */
package cpu_pipe_pkg;

    // Operation carried from decode into the ALU
    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI,
        ALU_LINK
    } alu_op_e;

    // Memory command travelling with the instruction
    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_op_e;

    localparam logic [31:0] RESET_PC = 32'h0000_0000;
    localparam int REG_COUNT = 32;

endpackage

/* design/reg_file.sv */
`timescale 1ns/1ps

module reg_file
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      we_i,
    input  reg_addr_t waddr_i,
    input  word_t     wdata_i,
    input  reg_addr_t raddr_a_i,
    input  reg_addr_t raddr_b_i,
    output word_t     rdata_a_o,
    output word_t     rdata_b_o
);

    word_t regs [REG_COUNT];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Same-cycle write is visible to decode
    assign rdata_a_o = (raddr_a_i == '0) ? '0 :
                       (we_i && (waddr_i == raddr_a_i)) ? wdata_i : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 :
                       (we_i && (waddr_i == raddr_b_i)) ? wdata_i : regs[raddr_b_i];

endmodule

/* design/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n_i,
    input  logic  branch_taken_i,
    input  word_t branch_target_i,
    input  logic  stall_i,
    input  word_t rom_data_i,
    output word_t rom_addr_o,
    output logic  rom_ce_o,
    output word_t id_pc_o,
    output word_t id_inst_o
);

    word_t pc;
    logic  ce;

    // PC only moves once the ROM is enabled; a stall wins over a branch
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc <= RESET_PC;
            ce <= 1'b0;
        end else begin
            ce <= 1'b1;
            if (ce && !stall_i) begin
                pc <= branch_taken_i ? branch_target_i : pc + 32'd4;
            end
        end
    end

    // IF/ID register, NOP while the ROM is still disabled
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_inst_o <= '0;
        end else if (!stall_i) begin
            id_inst_o <= ce ? rom_data_i : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            id_pc_o <= pc;
        end
    end

    assign rom_addr_o = pc;
    assign rom_ce_o   = ce;

endmodule

/* design/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;
(
    input  word_t     id_pc_i,
    input  word_t     id_inst_i,
    output reg_addr_t rs_addr_o,
    output reg_addr_t rt_addr_o,
    input  word_t     rs_data_i,
    input  word_t     rt_data_i,
    input  logic      ex_wr_en_i,
    input  reg_addr_t ex_wr_addr_i,
    input  word_t     ex_wr_data_i,
    input  mem_op_e   ex_mem_op_i,
    input  logic      mem_wr_en_i,
    input  reg_addr_t mem_wr_addr_i,
    input  word_t     mem_wr_data_i,
    output logic      branch_taken_o,
    output word_t     branch_target_o,
    output logic      stall_req_o,
    output alu_op_e   alu_op_o,
    output mem_op_e   mem_op_o,
    output word_t     operand_a_o,
    output word_t     operand_b_o,
    output word_t     store_data_o,
    output logic      wr_en_o,
    output reg_addr_t wr_addr_o
);

    opcode_e          opcode;
    funct_e           funct;
    reg_addr_t        rs;
    reg_addr_t        rt;
    reg_addr_t        rd;
    logic [IMM_W-1:0] imm;
    word_t            imm_sext;
    word_t            imm_zext;
    word_t            pc_plus4;
    word_t            br_target;
    word_t            jump_target;
    word_t            rs_val;
    word_t            rt_val;
    logic             ex_hit_rs;
    logic             ex_hit_rt;
    logic             mem_hit_rs;
    logic             mem_hit_rt;
    logic             uses_rs;
    logic             uses_rt;

    assign opcode = opcode_e'(id_inst_i[31:26]);
    assign funct  = funct_e'(id_inst_i[5:0]);
    assign rs     = id_inst_i[25:21];
    assign rt     = id_inst_i[20:16];
    assign rd     = id_inst_i[15:11];
    assign imm    = id_inst_i[IMM_W-1:0];

    assign imm_sext = {{(32-IMM_W){imm[IMM_W-1]}}, imm};
    assign imm_zext = {{(32-IMM_W){1'b0}}, imm};

    assign pc_plus4    = id_pc_i + 32'd4;
    assign br_target   = pc_plus4 + {imm_sext[29:0], 2'b00};
    assign jump_target = {pc_plus4[31:28], id_inst_i[JUMP_W-1:0], 2'b00};

    assign rs_addr_o = rs;
    assign rt_addr_o = rt;

    // Forwarding, youngest producer first; register 0 is never forwarded
    assign ex_hit_rs  = ex_wr_en_i && (ex_wr_addr_i == rs) && (rs != '0);
    assign ex_hit_rt  = ex_wr_en_i && (ex_wr_addr_i == rt) && (rt != '0);
    assign mem_hit_rs = mem_wr_en_i && (mem_wr_addr_i == rs) && (rs != '0);
    assign mem_hit_rt = mem_wr_en_i && (mem_wr_addr_i == rt) && (rt != '0);

    assign rs_val = ex_hit_rs ? ex_wr_data_i : (mem_hit_rs ? mem_wr_data_i : rs_data_i);
    assign rt_val = ex_hit_rt ? ex_wr_data_i : (mem_hit_rt ? mem_wr_data_i : rt_data_i);

    always_comb begin
        alu_op_o        = ALU_NOP;
        mem_op_o        = MEM_NONE;
        operand_a_o     = rs_val;
        operand_b_o     = rt_val;
        wr_en_o         = 1'b0;
        wr_addr_o       = rt;
        uses_rs         = 1'b0;
        uses_rt         = 1'b0;
        branch_taken_o  = 1'b0;
        branch_target_o = br_target;
        case (opcode)
            OP_SPECIAL: begin
                wr_addr_o = rd;
                uses_rs   = 1'b1;
                uses_rt   = 1'b1;
                wr_en_o   = 1'b1;
                case (funct)
                    FN_ADDU: alu_op_o = ALU_ADD;
                    FN_SUBU: alu_op_o = ALU_SUB;
                    FN_AND:  alu_op_o = ALU_AND;
                    FN_OR:   alu_op_o = ALU_OR;
                    FN_XOR:  alu_op_o = ALU_XOR;
                    FN_SLT:  alu_op_o = ALU_SLT;
                    default: wr_en_o  = 1'b0;
                endcase
            end
            OP_ORI: begin
                alu_op_o    = ALU_OR;
                operand_b_o = imm_zext;
                wr_en_o     = 1'b1;
                uses_rs     = 1'b1;
            end
            OP_ADDIU: begin
                alu_op_o    = ALU_ADD;
                operand_b_o = imm_sext;
                wr_en_o     = 1'b1;
                uses_rs     = 1'b1;
            end
            OP_LUI: begin
                alu_op_o    = ALU_LUI;
                operand_b_o = imm_zext;
                wr_en_o     = 1'b1;
            end
            OP_LW: begin
                alu_op_o    = ALU_ADD;
                mem_op_o    = MEM_LOAD;
                operand_b_o = imm_sext;
                wr_en_o     = 1'b1;
                uses_rs     = 1'b1;
            end
            OP_SW: begin
                alu_op_o    = ALU_ADD;
                mem_op_o    = MEM_STORE;
                operand_b_o = imm_sext;
                uses_rs     = 1'b1;
                uses_rt     = 1'b1;
            end
            OP_BEQ: begin
                uses_rs        = 1'b1;
                uses_rt        = 1'b1;
                branch_taken_o = (rs_val == rt_val);
            end
            OP_BNE: begin
                uses_rs        = 1'b1;
                uses_rt        = 1'b1;
                branch_taken_o = (rs_val != rt_val);
            end
            OP_J: begin
                // Link value rides along but J itself writes nothing
                alu_op_o        = ALU_LINK;
                operand_a_o     = id_pc_i + 32'd8;
                branch_taken_o  = 1'b1;
                branch_target_o = jump_target;
            end
            default: ;
        endcase
    end

    assign store_data_o = rt_val;

    // Load in EX whose result is needed here
    assign stall_req_o = (ex_mem_op_i == MEM_LOAD) &&
                         ((uses_rs && ex_hit_rs) || (uses_rt && ex_hit_rt));

endmodule

/* design/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      bubble_i,
    input  alu_op_e   alu_op_i,
    input  mem_op_e   mem_op_i,
    input  word_t     operand_a_i,
    input  word_t     operand_b_i,
    input  word_t     store_data_i,
    input  logic      wr_en_i,
    input  reg_addr_t wr_addr_i,
    output mem_op_e   mem_op_o,
    output word_t     mem_addr_o,
    output word_t     store_data_o,
    output logic      wr_en_o,
    output reg_addr_t wr_addr_o,
    output word_t     wr_data_o
);

    alu_op_e alu_op;
    word_t   op_a;
    word_t   op_b;
    word_t   result;

    // ID/EX control, cleared on reset and on a bubble
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            alu_op   <= ALU_NOP;
            mem_op_o <= MEM_NONE;
            wr_en_o  <= 1'b0;
        end else if (bubble_i) begin
            alu_op   <= ALU_NOP;
            mem_op_o <= MEM_NONE;
            wr_en_o  <= 1'b0;
        end else begin
            alu_op   <= alu_op_i;
            mem_op_o <= mem_op_i;
            wr_en_o  <= wr_en_i;
        end
    end

    always_ff @(posedge clk) begin
        op_a         <= operand_a_i;
        op_b         <= operand_b_i;
        store_data_o <= store_data_i;
        wr_addr_o    <= wr_addr_i;
    end

    always_comb begin
        case (alu_op)
            ALU_ADD:  result = op_a + op_b;
            ALU_SUB:  result = op_a - op_b;
            ALU_AND:  result = op_a & op_b;
            ALU_OR:   result = op_a | op_b;
            ALU_XOR:  result = op_a ^ op_b;
            ALU_SLT:  result = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_LUI:  result = {op_b[IMM_W-1:0], {IMM_W{1'b0}}};
            ALU_LINK: result = op_a;
            default:  result = '0;
        endcase
    end

    // Address of loads and stores comes from the same adder
    assign mem_addr_o = result;
    assign wr_data_o  = result;

endmodule

/* design/memory_stage.sv */
`timescale 1ns/1ps

module memory_stage
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  mem_op_e   mem_op_i,
    input  word_t     mem_addr_i,
    input  word_t     store_data_i,
    input  logic      wr_en_i,
    input  reg_addr_t wr_addr_i,
    input  word_t     wr_data_i,
    input  word_t     ram_read_data_i,
    output logic      ram_ce_o,
    output logic      ram_write_en_o,
    output word_t     ram_addr_o,
    output word_t     ram_write_data_o,
    output logic      mem_wr_en_o,
    output reg_addr_t mem_wr_addr_o,
    output word_t     mem_wr_data_o,
    output logic      wb_en_o,
    output reg_addr_t wb_addr_o,
    output word_t     wb_data_o
);

    mem_op_e mem_op;
    word_t   alu_result;

    // EX/MEM register
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mem_op      <= MEM_NONE;
            mem_wr_en_o <= 1'b0;
        end else begin
            mem_op      <= mem_op_i;
            mem_wr_en_o <= wr_en_i;
        end
    end

    always_ff @(posedge clk) begin
        ram_addr_o       <= mem_addr_i;
        ram_write_data_o <= store_data_i;
        mem_wr_addr_o    <= wr_addr_i;
        alu_result       <= wr_data_i;
    end

    assign ram_ce_o       = (mem_op != MEM_NONE);
    assign ram_write_en_o = (mem_op == MEM_STORE);

    // Loads return in the same cycle
    assign mem_wr_data_o = (mem_op == MEM_LOAD) ? ram_read_data_i : alu_result;

    // MEM/WB register
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_en_o <= 1'b0;
        end else begin
            wb_en_o <= mem_wr_en_o;
        end
    end

    always_ff @(posedge clk) begin
        wb_addr_o <= mem_wr_addr_o;
        wb_data_o <= mem_wr_data_o;
    end

endmodule

/* design/mips_core.sv */
`timescale 1ns/1ps

module mips_core
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n_i,
    input  word_t rom_data_i,
    output word_t rom_addr_o,
    output logic  rom_ce_o,
    input  word_t ram_read_data_i,
    output word_t ram_addr_o,
    output word_t ram_write_data_o,
    output logic  ram_write_en_o,
    output logic  ram_ce_o
);

    // Fetch to decode
    word_t     id_pc;
    word_t     id_inst;
    logic      branch_taken;
    word_t     branch_target;
    logic      stall_req;

    // Decode and register file
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t     rs_data;
    word_t     rt_data;

    // Decode to execute
    alu_op_e   id_alu_op;
    mem_op_e   id_mem_op;
    word_t     id_operand_a;
    word_t     id_operand_b;
    word_t     id_store_data;
    logic      id_wr_en;
    reg_addr_t id_wr_addr;

    // Execute to memory, also forwarded
    mem_op_e   ex_mem_op;
    word_t     ex_mem_addr;
    word_t     ex_store_data;
    logic      ex_wr_en;
    reg_addr_t ex_wr_addr;
    word_t     ex_wr_data;

    // Memory feedback and write-back
    logic      mem_wr_en;
    reg_addr_t mem_wr_addr;
    word_t     mem_wr_data;
    logic      wb_en;
    reg_addr_t wb_addr;
    word_t     wb_data;

    fetch_stage u_fetch (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .branch_taken_i  (branch_taken),
        .branch_target_i (branch_target),
        .stall_i         (stall_req),
        .rom_data_i      (rom_data_i),
        .rom_addr_o      (rom_addr_o),
        .rom_ce_o        (rom_ce_o),
        .id_pc_o         (id_pc),
        .id_inst_o       (id_inst)
    );

    decode_stage u_decode (
        .id_pc_i         (id_pc),
        .id_inst_i       (id_inst),
        .rs_addr_o       (rs_addr),
        .rt_addr_o       (rt_addr),
        .rs_data_i       (rs_data),
        .rt_data_i       (rt_data),
        .ex_wr_en_i      (ex_wr_en),
        .ex_wr_addr_i    (ex_wr_addr),
        .ex_wr_data_i    (ex_wr_data),
        .ex_mem_op_i     (ex_mem_op),
        .mem_wr_en_i     (mem_wr_en),
        .mem_wr_addr_i   (mem_wr_addr),
        .mem_wr_data_i   (mem_wr_data),
        .branch_taken_o  (branch_taken),
        .branch_target_o (branch_target),
        .stall_req_o     (stall_req),
        .alu_op_o        (id_alu_op),
        .mem_op_o        (id_mem_op),
        .operand_a_o     (id_operand_a),
        .operand_b_o     (id_operand_b),
        .store_data_o    (id_store_data),
        .wr_en_o         (id_wr_en),
        .wr_addr_o       (id_wr_addr)
    );

    reg_file u_regs (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .we_i      (wb_en),
        .waddr_i   (wb_addr),
        .wdata_i   (wb_data),
        .raddr_a_i (rs_addr),
        .raddr_b_i (rt_addr),
        .rdata_a_o (rs_data),
        .rdata_b_o (rt_data)
    );

    execute_stage u_exec (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .bubble_i     (stall_req),
        .alu_op_i     (id_alu_op),
        .mem_op_i     (id_mem_op),
        .operand_a_i  (id_operand_a),
        .operand_b_i  (id_operand_b),
        .store_data_i (id_store_data),
        .wr_en_i      (id_wr_en),
        .wr_addr_i    (id_wr_addr),
        .mem_op_o     (ex_mem_op),
        .mem_addr_o   (ex_mem_addr),
        .store_data_o (ex_store_data),
        .wr_en_o      (ex_wr_en),
        .wr_addr_o    (ex_wr_addr),
        .wr_data_o    (ex_wr_data)
    );

    memory_stage u_mem (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .mem_op_i         (ex_mem_op),
        .mem_addr_i       (ex_mem_addr),
        .store_data_i     (ex_store_data),
        .wr_en_i          (ex_wr_en),
        .wr_addr_i        (ex_wr_addr),
        .wr_data_i        (ex_wr_data),
        .ram_read_data_i  (ram_read_data_i),
        .ram_ce_o         (ram_ce_o),
        .ram_write_en_o   (ram_write_en_o),
        .ram_addr_o       (ram_addr_o),
        .ram_write_data_o (ram_write_data_o),
        .mem_wr_en_o      (mem_wr_en),
        .mem_wr_addr_o    (mem_wr_addr),
        .mem_wr_data_o    (mem_wr_data),
        .wb_en_o          (wb_en),
        .wb_addr_o        (wb_addr),
        .wb_data_o        (wb_data)
    );

endmodule

/* sim/mips_core_assert.sv */
`timescale 1ns/1ps

module mips_core_assert
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;
(
    input logic  clk,
    input logic  rst_n_i,
    input word_t rom_addr_i,
    input word_t rom_data_i,
    input logic  rom_ce_i,
    input logic  ram_ce_i,
    input logic  ram_write_en_i,
    input word_t ram_addr_i,
    input word_t ram_write_data_i,
    input word_t ram_read_data_i
);

    // Result addresses used by the self-checking program
    localparam word_t FAIL_ADDR   = 32'h0000_03F0;
    localparam word_t SLOT_ADDR   = 32'h0000_03E0;
    localparam word_t LOAD_ADDR   = 32'h0000_03E4;
    localparam word_t SEED_ADDR   = 32'h0000_0080;
    localparam word_t LOAD_OFFSET = 32'h0000_1234;
    localparam word_t SLOT_COUNT  = 32'd6;

    int unsigned fail_count = 0;

    logic    prev_ce;
    logic    prev_hold;
    word_t   prev_addr;
    word_t   prev_word;
    word_t   older_addr;
    word_t   older_word;
    opcode_e older_op;
    word_t   older_next;
    word_t   older_target;
    logic    older_jump;
    logic    older_cond;
    logic    addr_hold;
    logic    addr_taken;
    word_t   exp_addr;
    word_t   seed_word;
    logic    ram_store;

    assign ram_store = ram_ce_i && ram_write_en_i;

    // Two most recent distinct fetches and their ROM words
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prev_ce    <= 1'b0;
            prev_hold  <= 1'b0;
            prev_addr  <= '0;
            prev_word  <= '0;
            older_addr <= '0;
            older_word <= '0;
        end else begin
            prev_ce   <= rom_ce_i;
            prev_hold <= prev_ce && addr_hold;
            if (rom_ce_i && !(prev_ce && addr_hold)) begin
                older_addr <= prev_addr;
                older_word <= prev_word;
                prev_addr  <= rom_addr_i;
                prev_word  <= rom_data_i;
            end
        end
    end

    // Word returned by the last load of the seeded location
    always_ff @(posedge clk) begin
        if (ram_ce_i && !ram_write_en_i && (ram_addr_i == SEED_ADDR)) begin
            seed_word <= ram_read_data_i;
        end
    end

    // Branch or jump fetched just before the delay slot
    assign older_op     = opcode_e'(older_word[31:26]);
    assign older_next   = older_addr + 32'd4;
    assign older_jump   = (older_op == OP_J);
    assign older_cond   = (older_op == OP_BEQ) || (older_op == OP_BNE);
    assign older_target = older_jump ?
                          {older_next[31:28], older_word[JUMP_W-1:0], 2'b00} :
                          older_next + {{(30-IMM_W){older_word[IMM_W-1]}},
                                        older_word[IMM_W-1:0], 2'b00};

    // Sequential unless the older fetch was a jump
    assign exp_addr   = older_jump ? older_target : prev_addr + 32'd4;
    assign addr_hold  = (rom_addr_i == prev_addr);
    assign addr_taken = older_cond && (rom_addr_i == older_target);

    reset_quiet: assert property (@(posedge clk)
        !rst_n_i |-> !rom_ce_i && !ram_ce_i && !ram_write_en_i)
        else begin
            fail_count++;
            $error("ROM or RAM enable is high while reset is asserted");
        end

    first_fetch: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(rom_ce_i) |-> rom_addr_i == RESET_PC)
        else begin
            fail_count++;
            $error("MISMATCH time=%0t rom_addr_o got 0x%08h expected 0x%08h",
                   $time, $sampled(rom_addr_i), RESET_PC);
        end

    pc_step: assert property (@(posedge clk) disable iff (!rst_n_i)
        prev_ce |-> addr_hold || addr_taken || (rom_addr_i == exp_addr))
        else begin
            fail_count++;
            $error("MISMATCH time=%0t rom_addr_o got 0x%08h expected 0x%08h",
                   $time, $sampled(rom_addr_i), $sampled(exp_addr));
        end

    hold_once: assert property (@(posedge clk) disable iff (!rst_n_i)
        prev_ce && addr_hold |-> !prev_hold)
        else begin
            fail_count++;
            $error("Fetch address was held for more than one cycle");
        end

    no_fail_store: assert property (@(posedge clk) disable iff (!rst_n_i)
        ram_store |-> ram_addr_i != FAIL_ADDR)
        else begin
            fail_count++;
            $error("Program test %0d failed and stored to FAIL_ADDR",
                   $sampled(ram_write_data_i));
        end

    write_needs_ce: assert property (@(posedge clk) disable iff (!rst_n_i)
        ram_write_en_i |-> ram_ce_i)
        else begin
            fail_count++;
            $error("ram_write_en_o is high while ram_ce_o is low");
        end

    load_result: assert property (@(posedge clk) disable iff (!rst_n_i)
        ram_store && (ram_addr_i == LOAD_ADDR) |->
            ram_write_data_i == seed_word + LOAD_OFFSET)
        else begin
            fail_count++;
            $error("MISMATCH time=%0t ram_write_data_o got 0x%08h expected 0x%08h",
                   $time, $sampled(ram_write_data_i), $sampled(seed_word) + LOAD_OFFSET);
        end

    slot_total: assert property (@(posedge clk) disable iff (!rst_n_i)
        ram_store && (ram_addr_i == SLOT_ADDR) |-> ram_write_data_i == SLOT_COUNT)
        else begin
            fail_count++;
            $error("MISMATCH time=%0t ram_write_data_o got 0x%08h expected 0x%08h",
                   $time, $sampled(ram_write_data_i), SLOT_COUNT);
        end

endmodule

/* sim/tb_mips_core.sv */
`timescale 1ns/1ps

module tb_mips_core
    import cpu_isa_pkg::*;
();

    localparam int    ROM_WORDS  = 64;
    localparam int    RAM_WORDS  = 256;
    localparam int    FAIL_IDX   = 48;
    localparam int    DONE_LIMIT = 500;
    localparam word_t FAIL_ADDR  = 32'h0000_03F0;
    localparam word_t DONE_ADDR  = 32'h0000_03F4;
    localparam word_t SLOT_ADDR  = 32'h0000_03E0;
    localparam word_t LOAD_ADDR  = 32'h0000_03E4;
    localparam word_t SEED_ADDR  = 32'h0000_0080;

    logic  clk;
    logic  rst_n_i;
    word_t rom_data;
    word_t rom_addr;
    logic  rom_ce;
    word_t ram_read_data;
    word_t ram_addr;
    word_t ram_write_data;
    logic  ram_write_en;
    logic  ram_ce;

    word_t rom [ROM_WORDS];
    word_t ram [RAM_WORDS];
    int    pc_idx;
    int    done_idx;
    logic  done_seen;
    logic  load_seen;
    logic  slot_seen;
    int    timeout_count;
    int    other_errors;
    int    assert_errors;

    mips_core u_dut (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .rom_data_i       (rom_data),
        .rom_addr_o       (rom_addr),
        .rom_ce_o         (rom_ce),
        .ram_read_data_i  (ram_read_data),
        .ram_addr_o       (ram_addr),
        .ram_write_data_o (ram_write_data),
        .ram_write_en_o   (ram_write_en),
        .ram_ce_o         (ram_ce)
    );

    bind mips_core mips_core_assert u_checks (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .rom_addr_i       (rom_addr_o),
        .rom_data_i       (rom_data_i),
        .rom_ce_i         (rom_ce_o),
        .ram_ce_i         (ram_ce_o),
        .ram_write_en_i   (ram_write_en_o),
        .ram_addr_i       (ram_addr_o),
        .ram_write_data_i (ram_write_data_o),
        .ram_read_data_i  (ram_read_data_i)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Both memories answer in the same cycle
    assign rom_data      = rom_ce ? rom[rom_addr[7:2]] : '0;
    assign ram_read_data = ram[ram_addr[9:2]];

    always @(posedge clk) begin
        if (ram_ce && ram_write_en) begin
            ram[ram_addr[9:2]] <= ram_write_data;
            done_seen <= done_seen || (ram_addr == DONE_ADDR);
            load_seen <= load_seen || (ram_addr == LOAD_ADDR);
            slot_seen <= slot_seen || (ram_addr == SLOT_ADDR);
        end
    end

    function automatic word_t r_format(funct_e fn, int rd, int rs, int rt);
        return {OP_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic word_t i_format(opcode_e op, int rs, int rt, logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic word_t j_format(int idx);
        return {OP_J, 26'(idx)};
    endfunction

    // Branch offset from the slot after pc_idx to the failure handler
    function automatic logic [15:0] offset_to_fail();
        return 16'(FAIL_IDX - (pc_idx + 1));
    endfunction

    task automatic append_inst(input word_t inst);
        rom[pc_idx] = inst;
        pc_idx++;
    endtask

    // r10 counts executed delay slots
    task automatic append_slot();
        append_inst(i_format(OP_ADDIU, 10, 10, 16'd1));
    endtask

    task automatic load_program();
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = '0;
        end
        pc_idx = 0;
        // Test 1 runs a dependent ALU chain ending in 0x80000100
        append_inst(i_format(OP_LUI, 0, 1, 16'h8000));
        append_inst(i_format(OP_ORI, 1, 1, 16'h00F0));
        append_inst(i_format(OP_ADDIU, 1, 2, 16'h0010));
        append_inst(r_format(FN_SUBU, 3, 2, 1));
        append_inst(r_format(FN_XOR, 3, 3, 2));
        append_inst(r_format(FN_AND, 3, 3, 1));
        append_inst(r_format(FN_OR, 3, 3, 2));
        append_inst(r_format(FN_SLT, 6, 3, 0));
        append_inst(r_format(FN_ADDU, 3, 3, 6));
        append_inst(i_format(OP_ADDIU, 3, 3, 16'hFFEF));
        append_inst(i_format(OP_LUI, 0, 7, 16'h8000));
        append_inst(i_format(OP_ORI, 7, 7, 16'h0100));
        append_inst(i_format(OP_ADDIU, 0, 4, 16'd1));
        append_inst(i_format(OP_BNE, 3, 7, offset_to_fail()));
        append_slot();
        // Test 2 feeds a load into an ALU op and into a branch
        append_inst(i_format(OP_ADDIU, 0, 4, 16'd2));
        append_inst(i_format(OP_LW, 0, 11, SEED_ADDR[15:0]));
        append_inst(i_format(OP_ADDIU, 11, 12, 16'h1234));
        append_inst(i_format(OP_SW, 0, 12, LOAD_ADDR[15:0]));
        append_inst(i_format(OP_LW, 0, 13, SEED_ADDR[15:0]));
        append_inst(i_format(OP_BNE, 13, 11, offset_to_fail()));
        append_slot();
        // In test 3 taken paths skip a store to FAIL_ADDR
        append_inst(i_format(OP_ADDIU, 0, 4, 16'd3));
        append_inst(i_format(OP_ADDIU, 0, 14, 16'd5));
        append_inst(i_format(OP_ADDIU, 0, 15, 16'd5));
        append_inst(i_format(OP_BEQ, 14, 15, 16'd2));
        append_slot();
        append_inst(i_format(OP_SW, 0, 4, FAIL_ADDR[15:0]));
        append_inst(i_format(OP_BEQ, 1, 0, offset_to_fail()));
        append_slot();
        append_inst(i_format(OP_BNE, 1, 0, 16'd2));
        append_slot();
        append_inst(i_format(OP_SW, 0, 4, FAIL_ADDR[15:0]));
        append_inst(j_format(pc_idx + 3));
        append_slot();
        append_inst(i_format(OP_SW, 0, 4, FAIL_ADDR[15:0]));
        append_inst(i_format(OP_SW, 0, 10, SLOT_ADDR[15:0]));
        done_idx = pc_idx;
        append_inst(i_format(OP_ADDIU, 0, 9, 16'd1));
        append_inst(i_format(OP_SW, 0, 9, DONE_ADDR[15:0]));
        append_inst(j_format(pc_idx));
        append_inst('0);
        // Failure handler records the test number and finishes
        pc_idx = FAIL_IDX;
        append_inst(i_format(OP_SW, 0, 4, FAIL_ADDR[15:0]));
        append_inst(j_format(done_idx));
        append_inst('0);
    endtask

    task automatic wait_for_done();
        int cycles;
        cycles = 0;
        while (!done_seen && cycles < DONE_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!done_seen) begin
            timeout_count++;
            $display("Timeout: no store to DONE_ADDR within %0d cycles", DONE_LIMIT);
        end
    endtask

    initial begin
        rst_n_i       = 1'b0;
        done_seen     = 1'b0;
        load_seen     = 1'b0;
        slot_seen     = 1'b0;
        timeout_count = 0;
        other_errors  = 0;
        void'($urandom(72303));
        for (int i = 0; i < RAM_WORDS; i++) begin
            ram[i] = {16'hC0DE, 16'(i * 4)};
        end
        ram[SEED_ADDR[9:2]] = $urandom;
        load_program();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        wait_for_done();
        repeat (3) @(negedge clk);
        if (done_seen && !load_seen) begin
            other_errors++;
            $display("Load-use result was never stored");
        end
        if (done_seen && !slot_seen) begin
            other_errors++;
            $display("Delay slot count was never stored");
        end
        assert_errors = u_dut.u_checks.fail_count;
        $display("Errors: assertions %0d, timeouts %0d, other %0d",
                 assert_errors, timeout_count, other_errors);
        if (assert_errors + timeout_count + other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* build.f */
design/cpu_isa_pkg.sv
design/cpu_pipe_pkg.sv
design/reg_file.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/mips_core.sv
sim/mips_core_assert.sv
sim/tb_mips_core.sv

/* Bender.yml */
package:
  name: mips_core

sources:
  - design/cpu_isa_pkg.sv
  - design/cpu_pipe_pkg.sv
  - design/reg_file.sv
  - design/fetch_stage.sv
  - design/decode_stage.sv
  - design/execute_stage.sv
  - design/memory_stage.sv
  - design/mips_core.sv
  - target: simulation
    files:
      - sim/mips_core_assert.sv
      - sim/tb_mips_core.sv
